// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_l2_cache_fa
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass or fail comes from the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/cache_cfg_pkg.sv
package cache_cfg_pkg;

	// --------------------------------------------------
	// cache geometry
	// --------------------------------------------------

	localparam int addr_w          = 16;                 // word address width
	localparam int block_w         = 2;                  // word offset bits within a block
	localparam int words_per_block = 1 << block_w;       // 4 words per block
	localparam int num_lines       = 8;                  // blocks held in the cache
	localparam int line_w          = $clog2(num_lines);  // line index width
	localparam int tag_w           = addr_w - block_w;   // fully associative so no index bits

	// --------------------------------------------------
	// word address views
	// --------------------------------------------------

	// the same 16 bits seen either as a flat address or split for the CAM
	typedef union packed {
		logic [addr_w-1:0] raw;              // flat word address
		struct packed {
			logic [tag_w-1:0]   tag;         // block address, compared in the CAM
			logic [block_w-1:0] offset;      // word within the block
		} fields;
	} word_addr_u;

endpackage

// File: hw/cache_controller.sv
module cache_controller (
	input  logic                                                  clock_bus_i,
	input  logic                                                  resetn_i,
	input  logic                                                  l1_req_i,
	input  cache_if_pkg::l1_cmd_t                                 l1_cmd_i,
	output logic                                                  l1_ack_o,
	input  logic                                                  cam_hit_i,
	input  logic [cache_cfg_pkg::line_w-1:0]                      cam_line_i,
	input  logic [cache_cfg_pkg::tag_w-1:0]                       cam_victim_tag_i,
	input  logic                                                  cam_victim_valid_i,
	output logic                                                  cam_wren_o,
	output logic [cache_cfg_pkg::line_w-1:0]                      cam_line_o,
	output logic [cache_cfg_pkg::tag_w-1:0]                       cam_tag_o,
	output logic [cache_cfg_pkg::line_w+cache_cfg_pkg::block_w-1:0] ram_addr_o,
	output logic                                                  ram_wren_o,
	output logic [31:0]                                           ram_wdata_o,
	input  logic [31:0]                                           ram_rdata_i,
	output logic                                                  mem_req_o,
	output cache_if_pkg::mem_cmd_t                                mem_cmd_o,
	input  logic                                                  mem_ack_i,
	input  logic [127:0]                                          mem_rblock_i,
	output cache_if_pkg::perf_evt_t                               perf_o
);
	import cache_cfg_pkg::*;
	import cache_if_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_LOOKUP, S_ACCESS, S_WB_GATHER, S_WB_HS, S_FILL_HS, S_FILL_WR, S_ACK
	} state_t;

	typedef logic [block_w:0] cnt_t;  // one spare bit for the gather drain

	state_t               state_q;
	l1_cmd_t              cmd_q;         // registered core request
	logic [line_w-1:0]    line_q;        // line being served
	logic [line_w-1:0]    vptr_q;        // round-robin victim
	logic [num_lines-1:0] dirty_q;
	cnt_t                 cnt_q;         // word counter for gather / fill
	logic [block_w-1:0]   wb_idx;
	logic [127:0]         fill_q;        // block returned by memory
	mem_cmd_t             mem_cmd_q;
	logic                 victim_dirty;
	logic                 fill_ack;
	logic                 word_walk;

	// --------------------------------------------------
	// datapath glue
	// --------------------------------------------------

	assign victim_dirty = cam_victim_valid_i && dirty_q[vptr_q];  // needs a write-back
	assign fill_ack     = (state_q == S_FILL_HS) && mem_req_o && mem_ack_i;
	assign word_walk    = (state_q == S_WB_GATHER) || (state_q == S_FILL_WR);
	assign wb_idx       = cnt_q[block_w-1:0] - 1'b1;  // RAM read lags the address by one

	assign cam_tag_o  = cmd_q.addr.fields.tag;  // lookup and install tag
	assign cam_line_o = vptr_q;                 // victim report / install line
	assign cam_wren_o = fill_ack;               // install as the block arrives

	assign ram_addr_o  = {line_q, word_walk ? cnt_q[block_w-1:0] : cmd_q.addr.fields.offset};
	assign ram_wren_o  = (state_q == S_FILL_WR) || ((state_q == S_ACCESS) && cmd_q.rw);
	assign ram_wdata_o = (state_q == S_FILL_WR) ? fill_q[cnt_q[block_w-1:0]*32 +: 32]
	                                            : cmd_q.wdata;

	assign mem_cmd_o = mem_cmd_q;

	// --------------------------------------------------
	// control FSM
	// --------------------------------------------------

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			state_q   <= S_IDLE;
			l1_ack_o  <= 1'b0;
			mem_req_o <= 1'b0;
			line_q    <= '0;
			vptr_q    <= '0;
			dirty_q   <= '0;
			cnt_q     <= '0;
			perf_o    <= '0;
		end else begin
			perf_o <= '0;  // flags are single pulses
			case (state_q)
				S_IDLE: if (l1_req_i) state_q <= S_LOOKUP;  // cmd latched this edge
				S_LOOKUP: begin
					cnt_q <= '0;
					if (cam_hit_i) begin
						line_q      <= cam_line_i;
						perf_o.hit  <= 1'b1;
						state_q     <= S_ACCESS;
					end else begin
						line_q      <= vptr_q;  // victim becomes the new home
						perf_o.miss <= 1'b1;
						if (victim_dirty) begin
							state_q <= S_WB_GATHER;
						end else begin
							mem_req_o <= 1'b1;      // straight to fill
							state_q   <= S_FILL_HS;
						end
					end
				end
				S_WB_GATHER: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == cnt_t'(words_per_block)) begin  // last word captured
						mem_req_o <= 1'b1;
						state_q   <= S_WB_HS;
					end
				end
				S_WB_HS: begin
					if (mem_req_o && mem_ack_i) begin
						mem_req_o        <= 1'b0;
						perf_o.writeback <= 1'b1;
					end else if (!mem_req_o && !mem_ack_i) begin
						mem_req_o <= 1'b1;   // handshake closed so the fill starts
						state_q   <= S_FILL_HS;
					end
				end
				S_FILL_HS: begin
					if (fill_ack) begin
						mem_req_o       <= 1'b0;
						dirty_q[line_q] <= 1'b0;          // fresh block is clean
						vptr_q          <= vptr_q + 1'b1; // advance after every fill
					end else if (!mem_req_o && !mem_ack_i) begin
						cnt_q   <= '0;
						state_q <= S_FILL_WR;
					end
				end
				S_FILL_WR: begin
					cnt_q <= cnt_q + 1'b1;  // one RAM word per cycle
					if (cnt_q == cnt_t'(words_per_block - 1)) state_q <= S_ACCESS;
				end
				S_ACCESS: begin
					if (cmd_q.rw) begin
						dirty_q[line_q] <= 1'b1;
						l1_ack_o        <= 1'b1;  // write acks now while a read waits for RAM
					end
					state_q <= S_ACK;
				end
				S_ACK: begin
					if (!l1_ack_o) begin
						l1_ack_o <= 1'b1;         // read data valid from here on
					end else if (!l1_req_i) begin
						l1_ack_o <= 1'b0;
						state_q  <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// payload registers
	// --------------------------------------------------

	always_ff @(posedge clock_bus_i) begin
		case (state_q)
			S_IDLE: if (l1_req_i) cmd_q <= l1_cmd_i;
			S_LOOKUP: begin
				if (!cam_hit_i) begin
					mem_cmd_q.rw  <= victim_dirty;
					mem_cmd_q.tag <= victim_dirty ? cam_victim_tag_i : cmd_q.addr.fields.tag;
				end
			end
			S_WB_GATHER: begin
				if (cnt_q != '0) mem_cmd_q.wblock[wb_idx*32 +: 32] <= ram_rdata_i;
			end
			S_WB_HS: begin
				if (!mem_req_o && !mem_ack_i) begin
					mem_cmd_q.rw  <= 1'b0;    // fill of the missed block
					mem_cmd_q.tag <= cmd_q.addr.fields.tag;
				end
			end
			S_FILL_HS: if (fill_ack) fill_q <= mem_rblock_i;
			default: ;
		endcase
	end

endmodule

// File: hw/cache_data_ram.sv
module cache_data_ram (
	input  logic                                                  clock_bus_i,
	input  logic [cache_cfg_pkg::line_w+cache_cfg_pkg::block_w-1:0] addr_i,  // {line, word}
	input  logic                                                  wren_i,
	input  logic [31:0]                                           wdata_i,
	output logic [31:0]                                           rdata_o
);
	import cache_cfg_pkg::*;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------

	logic [31:0] mem [num_lines*words_per_block];  // 32 words

	// write and registered read share the one edge
	// read returns the old word when both hit the same address
	always_ff @(posedge clock_bus_i) begin
		if (wren_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];  // valid one cycle after addr_i
	end

endmodule

// File: hw/cache_if_pkg.sv
package cache_if_pkg;

	// --------------------------------------------------
	// core side request
	// --------------------------------------------------

	// held stable by the core while l1_req is high
	typedef struct packed {
		logic                      rw;       // 1 = write
		cache_cfg_pkg::word_addr_u addr;     // word address
		logic [31:0]               wdata;    // store data, ignored on reads
	} l1_cmd_t;

	// --------------------------------------------------
	// memory side request
	// --------------------------------------------------

	// one transaction moves a whole block
	typedef struct packed {
		logic                                        rw;      // 1 = write-back
		logic [cache_cfg_pkg::tag_w-1:0]             tag;     // block address
		logic [cache_cfg_pkg::words_per_block*32-1:0] wblock; // word i at bits 32*i
	} mem_cmd_t;

	// --------------------------------------------------
	// performance events
	// --------------------------------------------------

	// single cycle pulses from the controller
	typedef struct packed {
		logic hit;        // first lookup hit
		logic miss;       // first lookup miss
		logic writeback;  // dirty block sent to memory
	} perf_evt_t;

endpackage

// File: hw/l2_cache_fa.sv
module l2_cache_fa (
	input  logic                   clock_bus_i,
	input  logic                   resetn_i,
	input  logic                   l1_req_i,
	input  cache_if_pkg::l1_cmd_t  l1_cmd_i,
	output logic                   l1_ack_o,
	output logic [31:0]            l1_rdata_o,
	output logic                   mem_req_o,
	output cache_if_pkg::mem_cmd_t mem_cmd_o,
	input  logic                   mem_ack_i,
	input  logic [127:0]           mem_rblock_i,
	input  logic [1:0]             metric_sel_i,
	output logic [31:0]            metric_o
);
	import cache_cfg_pkg::*;
	import cache_if_pkg::*;

	// --------------------------------------------------
	// internal wires
	// --------------------------------------------------

	logic                      cam_hit;
	logic [line_w-1:0]         cam_match_line;   // CAM -> controller
	logic [tag_w-1:0]          cam_victim_tag;
	logic                      cam_victim_valid;
	logic                      cam_wren;
	logic [line_w-1:0]         cam_victim_line;  // controller -> CAM
	logic [tag_w-1:0]          cam_tag;
	logic [line_w+block_w-1:0] ram_addr;         // {line, word}
	logic                      ram_wren;
	logic [31:0]               ram_wdata;
	perf_evt_t                 perf_evt;

	cache_controller cache_controller_inst (
		.clock_bus_i        (clock_bus_i),
		.resetn_i           (resetn_i),
		.l1_req_i           (l1_req_i),
		.l1_cmd_i           (l1_cmd_i),
		.l1_ack_o           (l1_ack_o),
		.cam_hit_i          (cam_hit),
		.cam_line_i         (cam_match_line),
		.cam_victim_tag_i   (cam_victim_tag),
		.cam_victim_valid_i (cam_victim_valid),
		.cam_wren_o         (cam_wren),
		.cam_line_o         (cam_victim_line),
		.cam_tag_o          (cam_tag),
		.ram_addr_o         (ram_addr),
		.ram_wren_o         (ram_wren),
		.ram_wdata_o        (ram_wdata),
		.ram_rdata_i        (l1_rdata_o),      // gather reads the same RAM port
		.mem_req_o          (mem_req_o),
		.mem_cmd_o          (mem_cmd_o),
		.mem_ack_i          (mem_ack_i),
		.mem_rblock_i       (mem_rblock_i),
		.perf_o             (perf_evt)
	);

	// lookup and install share one tag
	tag_cam_fa tag_cam_fa_inst (
		.clock_bus_i    (clock_bus_i),
		.resetn_i       (resetn_i),
		.tag_i          (cam_tag),
		.wren_i         (cam_wren),
		.line_i         (cam_victim_line),
		.wtag_i         (cam_tag),
		.hit_o          (cam_hit),
		.line_o         (cam_match_line),
		.victim_tag_o   (cam_victim_tag),
		.victim_valid_o (cam_victim_valid)
	);

	// read data feeds the core directly
	cache_data_ram cache_data_ram_inst (
		.clock_bus_i (clock_bus_i),
		.addr_i      (ram_addr),
		.wren_i      (ram_wren),
		.wdata_i     (ram_wdata),
		.rdata_o     (l1_rdata_o)
	);

	perf_counters perf_counters_inst (
		.clock_bus_i (clock_bus_i),
		.resetn_i    (resetn_i),
		.evt_i       (perf_evt),
		.sel_i       (metric_sel_i),
		.metric_o    (metric_o)
	);

endmodule

// File: hw/perf_counters.sv
module perf_counters (
	input  logic                    clock_bus_i,
	input  logic                    resetn_i,
	input  cache_if_pkg::perf_evt_t evt_i,     // pulses from the controller
	input  logic [1:0]              sel_i,     // metric select
	output logic [31:0]             metric_o
);

	logic [31:0] hit_cnt_q;
	logic [31:0] miss_cnt_q;
	logic [31:0] wb_cnt_q;

	// --------------------------------------------------
	// event counters
	// --------------------------------------------------

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			hit_cnt_q  <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
		end else begin
			if (evt_i.hit)       hit_cnt_q  <= hit_cnt_q + 32'd1;
			if (evt_i.miss)      miss_cnt_q <= miss_cnt_q + 32'd1;
			if (evt_i.writeback) wb_cnt_q   <= wb_cnt_q + 32'd1;
		end
	end

	// --------------------------------------------------
	// registered read-out
	// --------------------------------------------------

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			metric_o <= '0;
		end else begin
			case (sel_i)
				2'd0:    metric_o <= hit_cnt_q;
				2'd1:    metric_o <= miss_cnt_q;
				2'd2:    metric_o <= wb_cnt_q;
				default: metric_o <= hit_cnt_q + miss_cnt_q;  // total accesses
			endcase
		end
	end

endmodule

// File: hw/tag_cam_fa.sv
module tag_cam_fa (
	input  logic                             clock_bus_i,
	input  logic                             resetn_i,
	input  logic [cache_cfg_pkg::tag_w-1:0]  tag_i,          // lookup tag
	input  logic                             wren_i,         // install wtag_i at line_i
	input  logic [cache_cfg_pkg::line_w-1:0] line_i,         // install / victim line
	input  logic [cache_cfg_pkg::tag_w-1:0]  wtag_i,
	output logic                             hit_o,
	output logic [cache_cfg_pkg::line_w-1:0] line_o,         // matching line
	output logic [cache_cfg_pkg::tag_w-1:0]  victim_tag_o,   // tag stored at line_i
	output logic                             victim_valid_o
);
	import cache_cfg_pkg::*;

	logic [tag_w-1:0]     tag_q [num_lines];  // stored tags
	logic [num_lines-1:0] valid_q;
	logic [num_lines-1:0] match;

	// --------------------------------------------------
	// parallel compare
	// --------------------------------------------------

	always_comb begin
		for (int i = 0; i < num_lines; i++) begin
			match[i] = valid_q[i] && (tag_q[i] == tag_i);  // invalid lines never hit
		end
	end

	assign hit_o = |match;

	// one-hot to index as at most one line matches
	always_comb begin
		line_o = '0;
		for (int i = 0; i < num_lines; i++) begin
			if (match[i]) begin
				line_o = line_w'(i);
			end
		end
	end

	// --------------------------------------------------
	// install
	// --------------------------------------------------

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			valid_q <= '0;                 // all lines start empty
		end else if (wren_i) begin
			valid_q[line_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (wren_i) begin
			tag_q[line_i] <= wtag_i;
		end
	end

	// victim info for the write-back address
	assign victim_tag_o   = tag_q[line_i];
	assign victim_valid_o = valid_q[line_i];

endmodule

// File: sim.f
hw/cache_cfg_pkg.sv
hw/cache_if_pkg.sv
hw/tag_cam_fa.sv
hw/cache_data_ram.sv
hw/cache_controller.sv
hw/perf_counters.sv
hw/l2_cache_fa.sv
testbench/tb_l2_cache_fa.sv

// File: testbench/tb_l2_cache_fa.sv
module tb_l2_cache_fa;
	timeunit 1ns;
	timeprecision 100ps;
	import cache_cfg_pkg::*;
	import cache_if_pkg::*;

	localparam int num_req        = 400;
	localparam int cycles_per_req = 60;  // generous bound per request
	localparam int clk_period     = 4;
	localparam logic [tag_w-1:0] base_tag = 14'h0a40;  // start of the 16-block window

	logic         clock_bus_i;
	logic         resetn_i;
	logic         l1_req_i;
	l1_cmd_t      l1_cmd_i;
	logic         l1_ack_o;
	logic [31:0]  l1_rdata_o;
	logic         mem_req_o;
	mem_cmd_t     mem_cmd_o;
	logic         mem_ack_i;
	logic [127:0] mem_rblock_i;
	logic [1:0]   metric_sel_i;
	logic [31:0]  metric_o;

	logic [31:0]      backing [1 << addr_w];     // memory behind the cache
	logic [31:0]      model_word [1 << addr_w];  // current value of every word
	logic [tag_w-1:0] m_tag [num_lines];         // model of the cache lines
	logic             m_valid [num_lines];
	logic             m_dirty [num_lines];
	int               m_ptr;                     // round-robin victim
	mem_cmd_t         exp_q [$];                 // memory transactions still to come
	logic [31:0]      rng_state = 32'd92333;
	int               hit_cnt = 0;
	int               miss_cnt = 0;
	int               wb_cnt = 0;
	int               check_count = 0;
	int               error_count = 0;

	l2_cache_fa l2_cache_fa_inst (
		.clock_bus_i  (clock_bus_i),
		.resetn_i     (resetn_i),
		.l1_req_i     (l1_req_i),
		.l1_cmd_i     (l1_cmd_i),
		.l1_ack_o     (l1_ack_o),
		.l1_rdata_o   (l1_rdata_o),
		.mem_req_o    (mem_req_o),
		.mem_cmd_o    (mem_cmd_o),
		.mem_ack_i    (mem_ack_i),
		.mem_rblock_i (mem_rblock_i),
		.metric_sel_i (metric_sel_i),
		.metric_o     (metric_o)
	);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);  // xorshift32
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// power-up contents mix in every address bit
	function automatic logic [31:0] fill_word(input int a);
		return {16'(a) ^ 16'hc3a5, 16'(a)};
	endfunction

	task automatic check_value(input string name, input logic [159:0] actual,
	                           input logic [159:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("mismatch %s: got %h expected %h", name, actual, expected);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("error: %s", msg);
	endtask

	task automatic read_metric(input logic [1:0] sel, input int expected);
		@(posedge clock_bus_i);
		metric_sel_i <= sel;
		repeat (2) @(posedge clock_bus_i);  // selector held 2 cycles
		@(negedge clock_bus_i);
		check_value($sformatf("metric_o sel %0d", sel), metric_o, 160'(expected));
	endtask

	// --------------------------------------------------
	// one core request through the model and then the DUT
	// --------------------------------------------------

	task automatic run_request(input l1_cmd_t cmd);
		logic [tag_w-1:0]  tag;
		logic [addr_w-1:0] wb_addr;
		logic              hit;
		int                line;
		int                lat;
		mem_cmd_t          exp_cmd;
		logic [31:0]       exp_rdata;
		tag  = cmd.addr.fields.tag;
		hit  = 1'b0;
		line = 0;
		for (int i = 0; i < num_lines; i++) begin
			if (m_valid[i] && m_tag[i] == tag) begin
				hit  = 1'b1;
				line = i;
			end
		end
		if (hit) begin
			hit_cnt++;
		end else begin
			miss_cnt++;
			line = m_ptr;
			if (m_valid[line] && m_dirty[line]) begin  // dirty victim goes out first
				exp_cmd.rw  = 1'b1;
				exp_cmd.tag = m_tag[line];
				for (int w = 0; w < words_per_block; w++) begin
					wb_addr = {m_tag[line], block_w'(w)};
					exp_cmd.wblock[w*32 +: 32] = model_word[wb_addr];
				end
				exp_q.push_back(exp_cmd);
				wb_cnt++;
			end
			exp_cmd.rw     = 1'b0;  // fill of the missed block
			exp_cmd.tag    = tag;
			exp_cmd.wblock = '0;
			exp_q.push_back(exp_cmd);
			m_tag[line]   = tag;
			m_valid[line] = 1'b1;
			m_dirty[line] = 1'b0;
			m_ptr         = (m_ptr + 1) % num_lines;
		end
		exp_rdata = model_word[cmd.addr.raw];
		if (cmd.rw) begin
			model_word[cmd.addr.raw] = cmd.wdata;
			m_dirty[line] = 1'b1;
		end
		@(posedge clock_bus_i);
		l1_req_i <= 1'b1;
		l1_cmd_i <= cmd;
		@(posedge clock_bus_i);  // first edge that samples the request
		lat = 0;
		@(negedge clock_bus_i);
		while (!l1_ack_o) begin
			@(posedge clock_bus_i);
			lat++;
			@(negedge clock_bus_i);
		end
		if (hit && cmd.rw) check_value("write hit latency", 160'(lat), 160'd2);
		if (hit && !cmd.rw) check_value("read hit latency", 160'(lat), 160'd3);
		if (!cmd.rw) check_value("l1_rdata_o", l1_rdata_o, exp_rdata);
		if (exp_q.size() != 0) begin
			report_error("an expected memory transaction never happened");
		end
		exp_q.delete();
		@(posedge clock_bus_i);
		l1_req_i <= 1'b0;
		@(negedge clock_bus_i);
		while (l1_ack_o) @(negedge clock_bus_i);  // next request only after ack is low
	endtask

	// --------------------------------------------------
	// clock, memory responder, monitor, watchdog
	// --------------------------------------------------

	initial begin
		clock_bus_i = 1'b0;
		forever #(clk_period / 2) clock_bus_i = ~clock_bus_i;
	end

	initial begin
		mem_cmd_t     seen;
		mem_cmd_t     exp_cmd;
		logic [127:0] blk;
		int           delay;
		forever begin
			@(negedge clock_bus_i);
			if (resetn_i === 1'b1 && mem_req_o === 1'b1) begin
				seen = mem_cmd_o;
				blk  = '0;
				if (exp_q.size() == 0) begin
					report_error("memory request seen when none was expected");
				end else begin
					exp_cmd = exp_q.pop_front();
					check_value("mem_cmd_o.rw", seen.rw, exp_cmd.rw);
					check_value("mem_cmd_o.tag", seen.tag, exp_cmd.tag);
					if (exp_cmd.rw) begin
						check_value("mem_cmd_o.wblock", seen.wblock, exp_cmd.wblock);
					end
				end
				delay = int'(next_rand() % 6);  // 0 to 5 cycles
				repeat (delay) begin
					@(negedge clock_bus_i);
					check_value("mem_req_o while waiting", mem_req_o, 1'b1);
					check_value("mem_cmd_o while waiting", mem_cmd_o, seen);
				end
				for (int w = 0; w < words_per_block; w++) begin
					if (seen.rw) backing[{seen.tag, block_w'(w)}] = seen.wblock[w*32 +: 32];
					else blk[w*32 +: 32] = backing[{seen.tag, block_w'(w)}];
				end
				@(posedge clock_bus_i);
				mem_ack_i    <= 1'b1;
				mem_rblock_i <= blk;  // valid together with the ack
				@(negedge clock_bus_i);
				while (mem_req_o) @(negedge clock_bus_i);
				@(posedge clock_bus_i);
				mem_ack_i <= 1'b0;
			end
		end
	end

	// handshake order on both sides
	initial begin
		logic ack_prev;
		logic mreq_prev;
		ack_prev  = 1'b0;
		mreq_prev = 1'b0;
		forever begin
			@(negedge clock_bus_i);
			if (resetn_i === 1'b1) begin
				if (l1_ack_o && !ack_prev && !l1_req_i) begin
					report_error("l1_ack_o rose with no request");
				end
				if (!l1_ack_o && ack_prev && l1_req_i) begin
					report_error("l1_ack_o fell while l1_req_i was high");
				end
				if (!mem_req_o && mreq_prev && !mem_ack_i) begin
					report_error("mem_req_o fell before mem_ack_i rose");
				end
				if (mem_req_o && !mreq_prev && mem_ack_i) begin
					report_error("mem_req_o rose while mem_ack_i was high");
				end
			end
			ack_prev  = l1_ack_o;
			mreq_prev = mem_req_o;
		end
	end

	initial begin
		#(num_req * cycles_per_req * clk_period);
		$display("timeout: the run did not finish within %0d ns",
		         num_req * cycles_per_req * clk_period);
		$display("Checks failed");
		$finish;
	end

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------

	initial begin
		l1_cmd_t     cmd;
		logic [31:0] r;
		int          err_start;
		resetn_i     = 1'b0;
		l1_req_i     = 1'b0;
		l1_cmd_i     = '0;
		mem_ack_i    = 1'b0;
		mem_rblock_i = '0;
		metric_sel_i = 2'd0;
		m_ptr        = 0;
		for (int i = 0; i < (1 << addr_w); i++) begin
			backing[i]    = fill_word(i);
			model_word[i] = fill_word(i);  // model starts equal to memory
		end
		for (int i = 0; i < num_lines; i++) begin
			m_valid[i] = 1'b0;
			m_dirty[i] = 1'b0;
		end
		repeat (8) @(posedge clock_bus_i);
		resetn_i <= 1'b1;
		err_start = error_count;
		@(negedge clock_bus_i);
		check_value("l1_ack_o", l1_ack_o, 1'b0);
		check_value("mem_req_o", mem_req_o, 1'b0);
		for (int s = 0; s < 4; s++) read_metric(2'(s), 0);
		$display("test reset_state done, %0d errors", error_count - err_start);
		err_start = error_count;
		for (int n = 0; n < num_req; n++) begin
			r = next_rand();
			cmd.rw                = r[0];
			cmd.addr.fields.tag   = base_tag + tag_w'(r[7:4]);  // 16-block window
			cmd.addr.fields.offset = r[9:8];
			cmd.wdata             = next_rand();
			run_request(cmd);
			repeat (int'(r[11:10]) % 3) @(posedge clock_bus_i);  // idle gap
		end
		$display("test random_traffic done, %0d hits %0d misses %0d write-backs, %0d errors",
		         hit_cnt, miss_cnt, wb_cnt, error_count - err_start);
		err_start = error_count;
		read_metric(2'd0, hit_cnt);
		read_metric(2'd1, miss_cnt);
		read_metric(2'd2, wb_cnt);
		read_metric(2'd3, hit_cnt + miss_cnt);
		$display("test perf_counters done, %0d errors", error_count - err_start);
		$display("checks run %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
